// File: include/switch_defs.svh
`ifndef SWITCH_DEFS_SVH
`define SWITCH_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// write port sizing.
////////////////////////////////////////////////////////////////////////////

// front-end packet buffer, in half-words.
`define BUF_DEPTH 64

// number of storage banks behind the matcher.
`define NUM_BANKS 4

// half-words per bank.
// bank space is never returned, so a bank only fills.
`define BANK_DEPTH 256

// entries in the descriptor FIFO read by the host.
`define DESC_DEPTH 16

`endif

// File: source/pkt_pkg.sv
package pkt_pkg;

    // first half-word of a packet.
    // length counts half-words, header included.
    typedef struct packed {
        logic [8:0] len;
        logic [2:0] rsvd;
        logic [3:0] dest;
    } pkt_hdr_t;

    // one half-word off the write bus.
    // the header view only means something on the first word of a packet.
    typedef union packed {
        pkt_hdr_t    hdr;
        logic [15:0] raw;
    } pkt_word_u;

    // stream from the front-end buffer to the bank writer.
    typedef struct packed {
        logic        vld;
        logic [15:0] data;
        logic        eop;
    } xfer_t;

endpackage

// File: source/mem_pkg.sv
`include "switch_defs.svh"

package mem_pkg;

    // matcher decision, suc is a single-cycle pulse.
    typedef struct packed {
        logic       suc;
        logic [1:0] bank;
    } match_t;

    // one stored packet, as seen by the host.
    typedef struct packed {
        logic [1:0] bank;
        logic [7:0] start;
        logic [8:0] len;
        logic [3:0] dest;
    } pkt_desc_t;

    // used half-words per bank.
    typedef struct packed {
        logic [`NUM_BANKS-1:0][8:0] used;
    } bank_fill_t;

endpackage

// File: source/port_wr_frontend.sv
`timescale 1ns/1ns
`include "switch_defs.svh"

module port_wr_frontend (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_sop,
    input  logic               wr_eop,
    input  logic               wr_vld,
    input  pkt_pkg::pkt_word_u wr_data,
    input  mem_pkg::match_t    match,
    output logic               pause,
    output logic               match_enable,
    output pkt_pkg::pkt_hdr_t  hdr,
    output logic               ready_to_xfer,
    output pkt_pkg::xfer_t     xfer
);

    localparam int PTR_W = $clog2(`BUF_DEPTH);

    // write side, idle -> sop seen -> writing -> length reached.
    typedef enum logic [1:0] {WR_IDLE, WR_SOP, WR_DATA, WR_DONE} wr_state_t;
    // transfer side, stall means the buffer ran dry mid-packet.
    typedef enum logic [1:0] {XF_IDLE, XF_SEND, XF_STALL} xf_state_t;

    wr_state_t        wr_state;
    xf_state_t        xf_state;

    logic [15:0]      buffer [`BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] xfer_ptr;
    logic [PTR_W-1:0] wr_ptr_pls_1;
    logic [PTR_W-1:0] wr_ptr_pls_2;
    logic [PTR_W-1:0] wr_ptr_pls_3;
    logic [PTR_W-1:0] xfer_ptr_pls_1;
    // msb set means no packet end is known yet.
    logic [PTR_W:0]   end_ptr;
    logic [8:0]       wr_length;
    logic             pst_match;
    logic             hdr_wr;
    logic             data_wr;
    logic             last_wr;
    logic             last_rd;
    logic             near_full;
    logic             busy;

    assign wr_ptr_pls_1   = wr_ptr + PTR_W'(1);
    assign wr_ptr_pls_2   = wr_ptr + PTR_W'(2);
    assign wr_ptr_pls_3   = wr_ptr + PTR_W'(3);
    assign xfer_ptr_pls_1 = xfer_ptr + PTR_W'(1);

    // the header is the word written while in sop state.
    assign hdr_wr  = (wr_state == WR_SOP) && wr_vld;
    assign data_wr = (wr_state == WR_DATA) && wr_vld;
    // last half-word of the packet, by the length field.
    assign last_wr = (hdr_wr && wr_data.hdr.len == 9'd1) ||
                     (data_wr && (wr_length + 9'd1) == hdr.len);
    assign last_rd = (xf_state == XF_SEND) && ({1'b0, xfer_ptr_pls_1} == end_ptr);

    ////////////////////////////////////////////////////////////////////////////
    // write side.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: if (wr_sop) wr_state <= WR_SOP;
                WR_SOP: begin
                    if (last_wr) wr_state <= WR_DONE;
                    else if (hdr_wr) wr_state <= WR_DATA;
                end
                WR_DATA: if (last_wr) wr_state <= WR_DONE;
                // a new sop may share the cycle with eop.
                WR_DONE: begin
                    if (wr_sop) wr_state <= WR_SOP;
                    else if (wr_eop) wr_state <= WR_IDLE;
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // words outside a packet are dropped.
    always_ff @(posedge clk) begin
        if (hdr_wr || data_wr) buffer[wr_ptr] <= wr_data.raw;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            wr_length <= '0;
        end else if (hdr_wr) begin
            wr_ptr    <= wr_ptr_pls_1;
            wr_length <= 9'd1;
        end else if (data_wr) begin
            wr_ptr    <= wr_ptr_pls_1;
            wr_length <= wr_length + 9'd1;
        end
    end

    // header decode.
    always_ff @(posedge clk) begin
        if (hdr_wr) hdr <= wr_data.hdr;
    end

    // end position is known as the last word goes in.
    always_ff @(posedge clk) begin
        if (!rst_n) end_ptr <= {1'b1, {PTR_W{1'b0}}};
        else if (last_wr) end_ptr <= {1'b0, wr_ptr_pls_1};
        else if (last_rd) end_ptr <= {1'b1, {PTR_W{1'b0}}};
    end

    ////////////////////////////////////////////////////////////////////////////
    // matching and transfer.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) match_enable <= 1'b0;
        else if (hdr_wr) match_enable <= 1'b1;
        else if (match.suc) match_enable <= 1'b0;
    end

    // holds a success that lands while the previous packet still drains.
    always_ff @(posedge clk) begin
        if (!rst_n) pst_match <= 1'b0;
        else if (ready_to_xfer) pst_match <= 1'b0;
        else if (match.suc) pst_match <= 1'b1;
    end

    assign ready_to_xfer = (xf_state == XF_IDLE) && (match.suc || pst_match);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xf_state <= XF_IDLE;
        end else begin
            case (xf_state)
                XF_IDLE: if (ready_to_xfer) xf_state <= XF_SEND;
                XF_SEND: begin
                    if (last_rd) xf_state <= XF_IDLE;
                    else if (xfer_ptr_pls_1 == wr_ptr) xf_state <= XF_STALL;
                end
                XF_STALL: if (xfer_ptr != wr_ptr) xf_state <= XF_SEND;
                default: xf_state <= XF_IDLE;
            endcase
        end
    end

    // one half-word per cycle in send state.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xfer_ptr <= '0;
            xfer.vld <= 1'b0;
            xfer.eop <= 1'b0;
        end else if (xf_state == XF_SEND) begin
            xfer_ptr  <= xfer_ptr_pls_1;
            xfer.vld  <= 1'b1;
            xfer.data <= buffer[xfer_ptr];
            xfer.eop  <= last_rd;
        end else begin
            xfer.vld <= 1'b0;
            xfer.eop <= 1'b0;
        end
    end

    // near full leaves room for two half-words already in flight.
    assign near_full = (wr_ptr_pls_1 == xfer_ptr) ||
                       (wr_ptr_pls_2 == xfer_ptr) ||
                       (wr_ptr_pls_3 == xfer_ptr);

    // a packet is unmatched or still leaving the buffer.
    // the next header waits so the bank fill is current when it is matched.
    assign busy = match_enable || pst_match || (xf_state != XF_IDLE) || xfer.vld;

    always_ff @(posedge clk) begin
        if (!rst_n) pause <= 1'b0;
        else pause <= near_full || ((wr_state != WR_DATA) && busy);
    end

endmodule

// File: source/sram_matcher.sv
`timescale 1ns/1ns
`include "switch_defs.svh"

module sram_matcher (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                match_enable,
    input  pkt_pkg::pkt_hdr_t   hdr,
    input  mem_pkg::bank_fill_t fill,
    output mem_pkg::match_t     match
);

    // wide enough for a completely empty bank.
    localparam int FREE_W = $clog2(`BANK_DEPTH) + 2;

    logic [FREE_W-1:0]     free_space [`NUM_BANKS];
    logic [`NUM_BANKS-1:0] fits;
    logic [FREE_W-1:0]     best_free;
    logic [1:0]            best_bank;
    logic                  found;
    // set once this packet has been given a bank.
    logic                  matched;

    ////////////////////////////////////////////////////////////////////////////
    // bank choice.
    ////////////////////////////////////////////////////////////////////////////

    // most free space wins.
    // strict compare keeps the lowest index on a tie.
    always_comb begin
        found     = 1'b0;
        best_free = '0;
        best_bank = '0;
        for (int b = 0; b < `NUM_BANKS; b++) begin
            free_space[b] = FREE_W'(`BANK_DEPTH) - FREE_W'(fill.used[b]);
            fits[b]       = free_space[b] >= FREE_W'(hdr.len);
            if (fits[b] && (!found || free_space[b] > best_free)) begin
                found     = 1'b1;
                best_free = free_space[b];
                best_bank = 2'(b);
            end
        end
    end

    // decision one cycle after enable.
    // with no room it simply keeps trying.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match   <= '0;
            matched <= 1'b0;
        end else begin
            match.suc <= 1'b0;
            if (!match_enable) begin
                matched <= 1'b0;
            end else if (!matched && found) begin
                match.suc  <= 1'b1;
                match.bank <= best_bank;
                matched    <= 1'b1;
            end
        end
    end

endmodule

// File: source/sram_bank_writer.sv
`timescale 1ns/1ns
`include "switch_defs.svh"

module sram_bank_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ready_to_xfer,
    input  mem_pkg::match_t     match,
    input  pkt_pkg::pkt_hdr_t   hdr,
    input  pkt_pkg::xfer_t      xfer,
    input  logic                desc_pop,
    input  logic [1:0]          rd_bank,
    input  logic [7:0]          rd_addr,
    output mem_pkg::bank_fill_t fill,
    output mem_pkg::pkt_desc_t  desc_head,
    output logic                desc_valid,
    output logic [15:0]         rd_data
);

    localparam int ADDR_W = $clog2(`BANK_DEPTH);
    localparam int DPTR_W = $clog2(`DESC_DEPTH);

    logic [15:0]        bank_mem [`NUM_BANKS][`BANK_DEPTH];
    logic [ADDR_W-1:0]  bank_wp [`NUM_BANKS];
    // packet being copied.
    logic [1:0]         cur_bank;
    logic [ADDR_W-1:0]  cur_start;
    pkt_pkg::pkt_hdr_t  cur_hdr;
    mem_pkg::pkt_desc_t desc_mem [`DESC_DEPTH];
    mem_pkg::pkt_desc_t desc_in;
    logic [DPTR_W:0]    desc_wp;
    logic [DPTR_W:0]    desc_rp;
    logic               desc_full;
    logic               desc_push;

    ////////////////////////////////////////////////////////////////////////////
    // bank writes.
    ////////////////////////////////////////////////////////////////////////////

    // bank and start address fixed when the transfer starts.
    always_ff @(posedge clk) begin
        if (ready_to_xfer) begin
            cur_bank  <= match.bank;
            cur_start <= bank_wp[match.bank];
            cur_hdr   <= hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer.vld) bank_mem[cur_bank][bank_wp[cur_bank]] <= xfer.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < `NUM_BANKS; b++) begin
                bank_wp[b] <= '0;
            end
        end else if (xfer.vld) begin
            bank_wp[cur_bank] <= bank_wp[cur_bank] + 1'b1;
        end
    end

    // fill grows by the header length once the whole packet is in.
    always_ff @(posedge clk) begin
        if (!rst_n) fill <= '0;
        else if (desc_push) fill.used[cur_bank] <= fill.used[cur_bank] + cur_hdr.len;
    end

    // registered read port for the host.
    always_ff @(posedge clk) begin
        rd_data <= bank_mem[rd_bank][rd_addr];
    end

    ////////////////////////////////////////////////////////////////////////////
    // descriptor FIFO.
    ////////////////////////////////////////////////////////////////////////////

    assign desc_push = xfer.vld && xfer.eop;
    assign desc_in   = '{bank: cur_bank, start: cur_start, len: cur_hdr.len, dest: cur_hdr.dest};

    // extra pointer bit tells full from empty.
    assign desc_full  = (desc_wp[DPTR_W] != desc_rp[DPTR_W]) &&
                        (desc_wp[DPTR_W-1:0] == desc_rp[DPTR_W-1:0]);
    assign desc_valid = desc_wp != desc_rp;
    assign desc_head  = desc_mem[desc_rp[DPTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (desc_push && !desc_full) desc_mem[desc_wp[DPTR_W-1:0]] <= desc_in;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            desc_wp <= '0;
            desc_rp <= '0;
        end else begin
            if (desc_push && !desc_full) desc_wp <= desc_wp + 1'b1;
            if (desc_pop && desc_valid) desc_rp <= desc_rp + 1'b1;
        end
    end

endmodule

// File: source/wb_pkt_reader.sv
`timescale 1ns/1ns

module wb_pkt_reader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [11:0]        wb_adr,
    input  logic [31:0]        wb_dat_i,
    input  mem_pkg::pkt_desc_t desc_head,
    input  logic               desc_valid,
    input  logic [15:0]        rd_data,
    output logic [31:0]        wb_dat_o,
    output logic               wb_ack,
    output logic               desc_pop,
    output logic [1:0]         rd_bank,
    output logic [7:0]         rd_addr
);

    logic        req;
    logic        sel_desc;
    logic        sel_scratch;
    logic        sel_mem;
    // host scratch word at address 1.
    logic [31:0] scratch;

    // new request, the cycle before its ack.
    assign req = wb_cyc && wb_stb && !wb_ack;

    // word addresses.
    assign sel_desc    = wb_adr == 12'h000;
    assign sel_scratch = wb_adr == 12'h001;
    assign sel_mem     = wb_adr[11:10] != 2'b00;

    // bank memory has one cycle of read latency, same as the ack.
    assign rd_bank = wb_adr[9:8];
    assign rd_addr = wb_adr[7:0];

    // one pop per write cycle.
    assign desc_pop = req && wb_we && sel_desc;

    always_ff @(posedge clk) begin
        if (!rst_n) wb_ack <= 1'b0;
        else wb_ack <= req;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) scratch <= '0;
        else if (req && wb_we && sel_scratch) scratch <= wb_dat_i;
    end

    // descriptor zero-extended, valid flag in bit 31.
    always_comb begin
        wb_dat_o = '0;
        if (sel_desc) wb_dat_o = {desc_valid, 8'h00, desc_valid ? desc_head : '0};
        else if (sel_scratch) wb_dat_o = scratch;
        else if (sel_mem) wb_dat_o = {16'h0000, rd_data};
    end

endmodule

// File: source/port_wr_top.sv
`timescale 1ns/1ns

module port_wr_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_sop,
    input  logic               wr_eop,
    input  logic               wr_vld,
    input  pkt_pkg::pkt_word_u wr_data,
    output logic               pause,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [11:0]        wb_adr,
    input  logic [31:0]        wb_dat_i,
    output logic [31:0]        wb_dat_o,
    output logic               wb_ack
);

    mem_pkg::match_t     match;
    logic                match_enable;
    pkt_pkg::pkt_hdr_t   hdr;
    logic                ready_to_xfer;
    pkt_pkg::xfer_t      xfer;
    mem_pkg::bank_fill_t fill;
    mem_pkg::pkt_desc_t  desc_head;
    logic                desc_valid;
    logic                desc_pop;
    logic [1:0]          rd_bank;
    logic [7:0]          rd_addr;
    logic [15:0]         rd_data;

    // header decode and buffering.
    port_wr_frontend i_frontend (
        .clk, .rst_n, .wr_sop, .wr_eop, .wr_vld, .wr_data, .match,
        .pause, .match_enable, .hdr, .ready_to_xfer, .xfer
    );

    sram_matcher i_matcher (
        .clk, .rst_n, .match_enable, .hdr, .fill, .match
    );

    sram_bank_writer i_bank_writer (
        .clk, .rst_n, .ready_to_xfer, .match, .hdr, .xfer, .desc_pop,
        .rd_bank, .rd_addr, .fill, .desc_head, .desc_valid, .rd_data
    );

    // host side.
    wb_pkt_reader i_wb_reader (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i,
        .desc_head, .desc_valid, .rd_data,
        .wb_dat_o, .wb_ack, .desc_pop, .rd_bank, .rd_addr
    );

endmodule

// File: testbench/tb_port_wr_top.sv
`timescale 1ns/1ns
`include "switch_defs.svh"

module tb_port_wr_top;

    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DELAY = 1;
    // lengths used by the bank choice sequence, and their sum.
    localparam int MIXED_COUNT = 7;
    localparam int MIXED_SUM   = 371;
    localparam int B2B_COUNT   = 10;
    localparam int B2B_MAX_LEN = 24;
    // upper bound of half-words sent over the whole run.
    localparam int TOTAL_HALF_WORDS = 10 + 200 + MIXED_SUM + B2B_COUNT * B2B_MAX_LEN;

    logic               clk;
    logic               rst_n;
    logic               wr_sop;
    logic               wr_eop;
    logic               wr_vld;
    pkt_pkg::pkt_word_u wr_data;
    logic               pause;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [11:0]        wb_adr;
    logic [31:0]        wb_dat_i;
    logic [31:0]        wb_dat_o;
    logic               wb_ack;

    integer             seed = 32'h467c;
    int                 fill_model [`NUM_BANKS];
    int                 mixed_len [MIXED_COUNT] = '{120, 60, 60, 90, 33, 1, 7};
    int                 pause_cycles = 0;
    // scoreboard of descriptors and half-words in arrival order.
    logic [22:0]        exp_desc [$];
    logic [15:0]        exp_words [$];

    port_wr_top i_dut (
        .clk, .rst_n, .wr_sop, .wr_eop, .wr_vld, .wr_data, .pause,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (pause) pause_cycles <= pause_cycles + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks.
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp)
        else stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    // pause is registered, so pause seen at an edge forbids wr_vld at that edge.
    vld_low_under_pause: assert property (@(posedge clk) disable iff (!rst_n)
        pause |-> !wr_vld)
    else stop_with_failure("wr_vld was still high one cycle after pause went high");

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_stb)
    else stop_with_failure("wb_ack was high while wb_stb was low");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
    else stop_with_failure("wb_ack stayed high for two cycles in a row");

    // the traffic is bounded, so a healthy run ends well before this limit.
    initial begin
        #(CLK_PERIOD * (40 * TOTAL_HALF_WORDS + 2000));
        stop_with_failure("watchdog expired before all packets were checked");
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus.
    ////////////////////////////////////////////////////////////////////////////

    // bank with the most free space that holds len, lowest index on a tie.
    function automatic int pick_bank(input int len);
        int best;
        int best_free;
        best      = -1;
        best_free = -1;
        for (int b = 0; b < `NUM_BANKS; b++) begin
            if (`BANK_DEPTH - fill_model[b] >= len && `BANK_DEPTH - fill_model[b] > best_free) begin
                best      = b;
                best_free = `BANK_DEPTH - fill_model[b];
            end
        end
        return best;
    endfunction

    // sop pulse, len half-words under pause, then the eop pulse.
    task automatic send_packet(input logic [3:0] dest, input int len, input int max_gap);
        logic [15:0] word;
        int          gap;
        int          bank;
        bank = pick_bank(len);
        if (bank < 0) stop_with_failure("no bank can hold the packet, the sequence is too long");
        exp_desc.push_back({2'(bank), 8'(fill_model[bank]), 9'(len), dest});
        fill_model[bank] = fill_model[bank] + len;
        wr_sop = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        wr_sop = 1'b0;
        for (int i = 0; i < len; i++) begin
            // length in bits 15 to 7, destination in bits 3 to 0.
            word = (i == 0) ? {9'(len), 3'b000, dest} : 16'($random(seed));
            exp_words.push_back(word);
            if (max_gap > 0) begin
                gap = int'({$random(seed)} % (max_gap + 1));
                repeat (gap) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
            end
            while (pause) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            wr_vld      = 1'b1;
            wr_data.raw = word;
            @(posedge clk);
            #DRIVE_DELAY;
            wr_vld = 1'b0;
        end
        wr_eop = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        wr_eop = 1'b0;
    endtask

    // master keeps stb up through the ack cycle.
    task automatic wb_access(input logic we, input logic [11:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        while (!wb_ack) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        rdata = wb_dat_o;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_desc(output logic [31:0] rdata);
        wb_access(1'b0, 12'h000, 32'h0, rdata);
        while (!rdata[31]) wb_access(1'b0, 12'h000, 32'h0, rdata);
    endtask

    // head descriptor against the scoreboard, then every stored half-word, then pop.
    task automatic check_next_desc(input string name);
        logic [31:0] rd;
        logic [22:0] exp;
        logic [1:0]  bank;
        logic [7:0]  start;
        int          len;
        exp   = exp_desc.pop_front();
        bank  = exp[22:21];
        start = exp[20:13];
        len   = int'(exp[12:4]);
        wait_desc(rd);
        check_value({name, " descriptor"}, {1'b1, 8'h00, exp}, rd);
        for (int i = 0; i < len; i++) begin
            wb_access(1'b0, {2'b01, bank, 8'(start + 8'(i))}, 32'h0, rd);
            check_value({name, " payload"}, {16'h0000, exp_words.pop_front()}, rd);
        end
        wb_access(1'b1, 12'h000, 32'h0, rd);
    endtask

    initial begin
        logic [31:0] rd;
        int          pause_start;
        rst_n    = 1'b0;
        wr_sop   = 1'b0;
        wr_eop   = 1'b0;
        wr_vld   = 1'b0;
        wr_data  = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        for (int b = 0; b < `NUM_BANKS; b++) fill_model[b] = 0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // control outputs idle after reset.
        check_value("reset pause", 32'h0, {31'h0, pause});
        check_value("reset wb_ack", 32'h0, {31'h0, wb_ack});
        wb_access(1'b0, 12'h000, 32'h0, rd);
        check_value("reset descriptor", 32'h0, rd);

        // host scratch word at address 1 returns what was written.
        wb_access(1'b1, 12'h001, 32'h5a3c_96e1, rd);
        wb_access(1'b0, 12'h001, 32'h0, rd);
        check_value("scratch readback", 32'h5a3c_96e1, rd);

        // header decode with port 5, 10 half-words, bank 0 at address 0.
        send_packet(4'd5, 10, 0);
        wait_desc(rd);
        check_value("header_decode", 32'h8000_00a5, rd);
        check_next_desc("header_decode");
        wb_access(1'b0, 12'h000, 32'h0, rd);
        check_value("header_decode after pop", 32'h0, rd);

        // back-pressure with a long packet and no gaps.
        pause_start = pause_cycles;
        send_packet(4'($random(seed)), 200, 0);
        check_next_desc("back_pressure");
        check_value("back_pressure pause seen", 32'h1, 32'(pause_cycles > pause_start));

        // bank choice over mixed lengths.
        for (int i = 0; i < MIXED_COUNT; i++) send_packet(4'(i), mixed_len[i], 1);
        for (int i = 0; i < MIXED_COUNT; i++) check_next_desc("bank_choice");

        // back-to-back packets with random gaps.
        for (int i = 0; i < B2B_COUNT; i++) begin
            send_packet(4'($random(seed)), 1 + int'({$random(seed)} % B2B_MAX_LEN), 3);
        end
        for (int i = 0; i < B2B_COUNT; i++) check_next_desc("back_to_back");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
source/pkt_pkg.sv
source/mem_pkg.sv
source/port_wr_frontend.sv
source/sram_matcher.sv
source/sram_bank_writer.sv
source/wb_pkt_reader.sv
source/port_wr_top.sv
testbench/tb_port_wr_top.sv

// File: Makefile
# Verilator build for the packet switch write port.

VERILATOR  ?= verilator
TB_TOP     ?= tb_port_wr_top
RTL_TOP    ?= port_wr_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard source/*.sv include/*.svh testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
